// File: gfx_top.f
+incdir+hw
hw/gfx_video_pkg.sv
hw/gfx_cpu_pkg.sv
hw/gfx_cfg_regs.sv
hw/gfx_vram.sv
hw/gfx_tilemap.sv
hw/gfx_obj.sv
hw/gfx_top.sv
test/gfx_tb.sv

// File: hw/gfx_cfg_regs.sv
`timescale 1ns/1ps
`include "gfx_defs.svh"

module gfx_cfg_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  gfx_cpu_pkg::cpu_bus_t bus,
    input  logic                  vctrl_cs,
    output logic                  yram_cs,
    output logic                  yram_we,
    output gfx_cpu_pkg::gfx_cfg_t cfg
);

    gfx_cpu_pkg::vctrl_region_e region;
    logic                       cfg_we;
    logic [7:0]                 cfg_mem [4];

    // top quarter of the space is config, the rest column RAM
    assign region  = gfx_cpu_pkg::vctrl_region_e'(bus.addr[9:8]);
    assign yram_cs = vctrl_cs && (region != gfx_cpu_pkg::rgn_cfg);
    assign yram_we = yram_cs && !bus.rnw;
    assign cfg_we  = vctrl_cs && (region == gfx_cpu_pkg::rgn_cfg) && !bus.rnw;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_mem[0] <= 8'd0;
            cfg_mem[1] <= `GFX_CFG1_RST;
            cfg_mem[2] <= 8'd0;
            cfg_mem[3] <= 8'd0;
        end else if (cfg_we) begin
            cfg_mem[bus.addr[1:0]] <= bus.dout;
        end
    end

    // byte 0: flip on bit 6, video enable on bit 4
    // byte 1: tilemap page on bit 6
    // bytes 2 and 3 are kept but drive nothing here
    assign cfg = '{
        flip:     cfg_mem[0][6],
        video_en: cfg_mem[0][4],
        tm_page:  cfg_mem[1][6]
    };

    // config writes must never leak into the column RAM
    a_region_excl: assert property (
        @(posedge clk) disable iff (rst)
        cfg_we |-> !yram_we && !yram_cs
    );

endmodule

// File: hw/gfx_cpu_pkg.sv
package gfx_cpu_pkg;

    // one access per select cycle
    typedef struct packed {
        logic        rnw;
        logic [12:0] addr;
        logic [7:0]  dout;
    } cpu_bus_t;

    // vctrl_cs space split by addr 9:8
    typedef enum logic [1:0] {
        rgn_col0,
        rgn_col1,
        rgn_col2,
        rgn_cfg
    } vctrl_region_e;

    // decoded config bits
    typedef struct packed {
        logic flip;
        logic video_en;
        logic tm_page;
    } gfx_cfg_t;

endpackage

// File: hw/gfx_defs.svh
`ifndef GFX_DEFS_SVH
`define GFX_DEFS_SVH

// code RAM, 4096 words of 16 bits
`define GFX_VRAM_AW 12

// column RAM, 1024 bytes
// bytes 0..31 hold sprite y, 512..543 hold column scroll
`define GFX_YRAM_AW 10

// visible pixels per line
`define GFX_LINE_W 256

// sprites scanned per line
`define GFX_OBJ_N 32

// config byte 1 after reset
`define GFX_CFG1_RST 8'd9

`endif

// File: hw/gfx_obj.sv
`timescale 1ns/1ps
`include "gfx_defs.svh"

module gfx_obj (
    input  logic                    clk,
    input  logic                    rst,
    input  gfx_cpu_pkg::gfx_cfg_t   cfg,
    input  logic                    hs,
    input  logic [8:0]              vrender,
    input  logic [8:0]              hdump,
    input  logic                    pxl_cen,
    input  logic                    slot,
    input  logic [15:0]             code_data,
    input  logic [7:0]              col_data,
    input  logic                    rom_ok,
    input  logic [31:0]             rom_data,
    output logic [11:0]             code_addr,
    output logic [9:0]              col_addr,
    output gfx_video_pkg::rom_req_t rom_req,
    output gfx_video_pkg::pxl_t     pxl
);

    gfx_video_pkg::obj_state_e state;
    gfx_video_pkg::pxl_t       line_buf [2][`GFX_LINE_W];
    gfx_video_pkg::pxl_t       rd_q;
    logic                      hs_l, pend, half_w, visible, last;
    logic [4:0]                idx, spr_pal;
    logic [7:0]                row, dy, spr_dy, spr_x;
    logic [10:0]               spr_code;
    logic [31:0]               rom_word;
    logic [7:0]                wr_x [8];
    logic [3:0]                nib  [8];

    // y byte n, code word 2048+2n, x word 2049+2n
    assign col_addr  = {5'd0, idx};
    assign code_addr = {1'b1, 5'd0, idx, state == gfx_video_pkg::obj_x};
    assign dy        = row - col_data;
    assign last      = idx == 5'(`GFX_OBJ_N - 1);
    assign visible   = hdump < `GFX_LINE_W;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            // x wraps at the buffer edge
            wr_x[i] = spr_x + 8'(i);
            nib[i]  = rom_word[4*i +: 4];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= gfx_video_pkg::obj_idle;
            hs_l     <= 1'b0;
            pend     <= 1'b0;
            half_w   <= 1'b0;
            idx      <= 5'd0;
            row      <= 8'd0;
            spr_dy   <= 8'd0;
            spr_x    <= 8'd0;
            spr_pal  <= 5'd0;
            spr_code <= 11'd0;
            rom_word <= 32'd0;
            rom_req  <= '0;
        end else begin
            hs_l <= hs;
            case (state)
                gfx_video_pkg::obj_idle: begin
                    if (hs && !hs_l) begin
                        idx    <= 5'd0;
                        row    <= vrender[7:0] ^ {8{cfg.flip}};
                        half_w <= vrender[0];
                        state  <= gfx_video_pkg::obj_y;
                    end
                end
                gfx_video_pkg::obj_y: begin
                    if (pend) begin
                        pend   <= 1'b0;
                        spr_dy <= dy;
                        // misses cost one slot only
                        if (dy < 8'd8)
                            state <= gfx_video_pkg::obj_code;
                        else if (last)
                            state <= gfx_video_pkg::obj_idle;
                        else
                            idx <= idx + 5'd1;
                    end else if (slot) begin
                        pend <= 1'b1;
                    end
                end
                gfx_video_pkg::obj_code: begin
                    if (pend) begin
                        pend     <= 1'b0;
                        spr_code <= code_data[10:0];
                        spr_pal  <= code_data[15:11];
                        state    <= gfx_video_pkg::obj_x;
                    end else if (slot) begin
                        pend <= 1'b1;
                    end
                end
                gfx_video_pkg::obj_x: begin
                    if (pend) begin
                        pend         <= 1'b0;
                        spr_x        <= code_data[7:0];
                        rom_req.cs   <= 1'b1;
                        // sprites live in the upper half of the ROM
                        rom_req.addr <= {1'b1, 3'd0, spr_code, spr_dy[2:0]};
                        state        <= gfx_video_pkg::obj_rom;
                    end else if (slot) begin
                        pend <= 1'b1;
                    end
                end
                gfx_video_pkg::obj_rom: begin
                    if (rom_ok) begin
                        rom_word   <= rom_data;
                        rom_req.cs <= 1'b0;
                        state      <= gfx_video_pkg::obj_write;
                    end
                end
                gfx_video_pkg::obj_write: begin
                    idx   <= idx + 5'd1;
                    state <= last ? gfx_video_pkg::obj_idle : gfx_video_pkg::obj_y;
                end
                default: state <= gfx_video_pkg::obj_idle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_buf <= '{default: '0};
            rd_q     <= '0;
            pxl      <= '0;
        end else begin
            if (pxl_cen) begin
                rd_q <= visible ? line_buf[~vrender[0]][hdump[7:0]] : '0;
                if (visible)
                    line_buf[~vrender[0]][hdump[7:0]] <= '0;
            end
            if (state == gfx_video_pkg::obj_write) begin
                // colour 0 is see-through, earlier sprites keep their pixels
                for (int i = 0; i < 8; i++)
                    if (nib[i] != 4'd0 && line_buf[half_w][wr_x[i]].color == 4'd0)
                        line_buf[half_w][wr_x[i]] <= '{pal: spr_pal, color: nib[i]};
            end
            pxl <= cfg.video_en ? rd_q : '0;
        end
    end

    a_rom_hold: assert property (
        @(posedge clk) disable iff (rst)
        rom_req.cs && !rom_ok |=> rom_req.cs && $stable(rom_req.addr)
    );

endmodule

// File: hw/gfx_tilemap.sv
`timescale 1ns/1ps
`include "gfx_defs.svh"

module gfx_tilemap (
    input  logic                    clk,
    input  logic                    rst,
    input  gfx_cpu_pkg::gfx_cfg_t   cfg,
    input  logic                    hs,
    input  logic [8:0]              vrender,
    input  logic [8:0]              hdump,
    input  logic                    pxl_cen,
    input  logic                    slot,
    input  logic [15:0]             code_data,
    input  logic [7:0]              col_data,
    input  logic                    rom_ok,
    input  logic [31:0]             rom_data,
    output logic [11:0]             code_addr,
    output logic [9:0]              col_addr,
    output gfx_video_pkg::rom_req_t rom_req,
    output gfx_video_pkg::pxl_t     pxl
);

    gfx_video_pkg::tm_state_e state;
    gfx_video_pkg::pxl_t      line_buf [2][`GFX_LINE_W];
    gfx_video_pkg::pxl_t      rd_q;
    logic                     hs_l, pend, half_w, visible;
    logic [4:0]               col, tile_pal;
    logic [7:0]               row, srow;
    logic [31:0]              rom_word;

    // scroll byte at 512 + column, entry in the lower half of code RAM
    assign col_addr  = {5'b10000, col};
    assign code_addr = {1'b0, cfg.tm_page, srow[7:3], col};
    assign visible   = hdump < `GFX_LINE_W;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= gfx_video_pkg::tm_idle;
            hs_l     <= 1'b0;
            pend     <= 1'b0;
            half_w   <= 1'b0;
            col      <= 5'd0;
            row      <= 8'd0;
            srow     <= 8'd0;
            tile_pal <= 5'd0;
            rom_word <= 32'd0;
            rom_req  <= '0;
        end else begin
            hs_l <= hs;
            case (state)
                gfx_video_pkg::tm_idle: begin
                    // hs edge starts the next line
                    if (hs && !hs_l) begin
                        col    <= 5'd0;
                        row    <= vrender[7:0] ^ {8{cfg.flip}};
                        half_w <= vrender[0];
                        state  <= gfx_video_pkg::tm_scroll;
                    end
                end
                gfx_video_pkg::tm_scroll: begin
                    // data comes back the cycle after our slot
                    if (pend) begin
                        pend  <= 1'b0;
                        srow  <= row + col_data;
                        state <= gfx_video_pkg::tm_code;
                    end else if (slot) begin
                        pend <= 1'b1;
                    end
                end
                gfx_video_pkg::tm_code: begin
                    if (pend) begin
                        pend         <= 1'b0;
                        tile_pal     <= code_data[15:11];
                        rom_req.cs   <= 1'b1;
                        rom_req.addr <= {4'd0, code_data[10:0], srow[2:0]};
                        state        <= gfx_video_pkg::tm_rom;
                    end else if (slot) begin
                        pend <= 1'b1;
                    end
                end
                gfx_video_pkg::tm_rom: begin
                    // stall here until the ROM answers
                    if (rom_ok) begin
                        rom_word   <= rom_data;
                        rom_req.cs <= 1'b0;
                        state      <= gfx_video_pkg::tm_write;
                    end
                end
                gfx_video_pkg::tm_write: begin
                    col   <= col + 5'd1;
                    state <= (col == 5'd31) ? gfx_video_pkg::tm_idle : gfx_video_pkg::tm_scroll;
                end
                default: state <= gfx_video_pkg::tm_idle;
            endcase
        end
    end

    // render half gets 8 pixels at once, display half is read and cleared
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_buf <= '{default: '0};
            rd_q     <= '0;
            pxl      <= '0;
        end else begin
            if (pxl_cen) begin
                rd_q <= visible ? line_buf[~vrender[0]][hdump[7:0]] : '0;
                if (visible)
                    line_buf[~vrender[0]][hdump[7:0]] <= '0;
            end
            if (state == gfx_video_pkg::tm_write) begin
                // lowest nibble is the leftmost pixel
                for (int i = 0; i < 8; i++)
                    line_buf[half_w][{col, 3'(i)}] <= '{pal: tile_pal, color: rom_word[4*i +: 4]};
            end
            pxl <= cfg.video_en ? rd_q : '0;
        end
    end

    a_rom_hold: assert property (
        @(posedge clk) disable iff (rst)
        rom_req.cs && !rom_ok |=> rom_req.cs && $stable(rom_req.addr)
    );

endmodule

// File: hw/gfx_top.sv
`timescale 1ns/1ps

module gfx_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic                    hs,
    input  logic [8:0]              vdump,
    input  logic [8:0]              vrender,
    input  logic [8:0]              hdump,
    input  gfx_cpu_pkg::cpu_bus_t   cpu_bus,
    input  logic                    vram_cs,
    input  logic                    vctrl_cs,
    input  logic [31:0]             scr_data,
    input  logic                    scr_ok,
    input  logic [31:0]             obj_data,
    input  logic                    obj_ok,
    output logic [7:0]              cpu_din,
    output logic                    flip,
    output gfx_video_pkg::rom_req_t scr_req,
    output gfx_video_pkg::rom_req_t obj_req,
    output gfx_video_pkg::pxl_t     scr_pxl,
    output gfx_video_pkg::pxl_t     obj_pxl
);

    gfx_cpu_pkg::gfx_cfg_t cfg;
    logic                  yram_cs, yram_we, tm_slot, obj_slot;
    logic [11:0]           tm_code_addr, obj_code_addr;
    logic [9:0]            tm_col_addr, obj_col_addr;
    logic [15:0]           code_data;
    logic [7:0]            col_data;

    // vdump is only here for the board-level port list
    assign flip = cfg.flip;

    gfx_cfg_regs u_cfg (
        .clk(clk), .rst(rst), .bus(cpu_bus), .vctrl_cs(vctrl_cs),
        .yram_cs(yram_cs), .yram_we(yram_we), .cfg(cfg)
    );

    gfx_vram u_vram (
        .clk(clk), .rst(rst), .bus(cpu_bus), .vram_cs(vram_cs),
        .yram_cs(yram_cs), .yram_we(yram_we),
        .tm_code_addr(tm_code_addr), .tm_col_addr(tm_col_addr),
        .obj_code_addr(obj_code_addr), .obj_col_addr(obj_col_addr),
        .cpu_din(cpu_din), .tm_slot(tm_slot), .obj_slot(obj_slot),
        .code_data(code_data), .col_data(col_data)
    );

    gfx_tilemap u_tilemap (
        .clk(clk), .rst(rst), .cfg(cfg), .hs(hs), .vrender(vrender),
        .hdump(hdump), .pxl_cen(pxl_cen), .slot(tm_slot),
        .code_data(code_data), .col_data(col_data),
        .rom_ok(scr_ok), .rom_data(scr_data),
        .code_addr(tm_code_addr), .col_addr(tm_col_addr),
        .rom_req(scr_req), .pxl(scr_pxl)
    );

    gfx_obj u_obj (
        .clk(clk), .rst(rst), .cfg(cfg), .hs(hs), .vrender(vrender),
        .hdump(hdump), .pxl_cen(pxl_cen), .slot(obj_slot),
        .code_data(code_data), .col_data(col_data),
        .rom_ok(obj_ok), .rom_data(obj_data),
        .code_addr(obj_code_addr), .col_addr(obj_col_addr),
        .rom_req(obj_req), .pxl(obj_pxl)
    );

endmodule

// File: hw/gfx_video_pkg.sv
package gfx_video_pkg;

    // palette on top, colour index below
    typedef struct packed {
        logic [4:0] pal;
        logic [3:0] color;
    } pxl_t;

    // graphics ROM strobe, 32-bit word address
    typedef struct packed {
        logic        cs;
        logic [17:0] addr;
    } rom_req_t;

    // graphics port phases, two per engine
    typedef enum logic [1:0] {
        tm_a,
        tm_b,
        obj_a,
        obj_b
    } slot_e;

    typedef enum logic [2:0] {
        tm_idle,
        tm_code,
        tm_scroll,
        tm_rom,
        tm_write
    } tm_state_e;

    typedef enum logic [2:0] {
        obj_idle,
        obj_y,
        obj_code,
        obj_x,
        obj_rom,
        obj_write
    } obj_state_e;

endpackage

// File: hw/gfx_vram.sv
`timescale 1ns/1ps
`include "gfx_defs.svh"

module gfx_vram (
    input  logic                          clk,
    input  logic                          rst,
    input  gfx_cpu_pkg::cpu_bus_t         bus,
    input  logic                          vram_cs,
    input  logic                          yram_cs,
    input  logic                          yram_we,
    input  logic [`GFX_VRAM_AW-1:0]       tm_code_addr,
    input  logic [`GFX_YRAM_AW-1:0]       tm_col_addr,
    input  logic [`GFX_VRAM_AW-1:0]       obj_code_addr,
    input  logic [`GFX_YRAM_AW-1:0]       obj_col_addr,
    output logic [7:0]                    cpu_din,
    output logic                          tm_slot,
    output logic                          obj_slot,
    output logic [15:0]                   code_data,
    output logic [7:0]                    col_data
);

    logic [15:0]             code_mem [2**`GFX_VRAM_AW];
    logic [7:0]              col_mem  [2**`GFX_YRAM_AW];
    logic [15:0]             cpu_code_q;
    logic [7:0]              cpu_col_q;
    logic                    rd_code, rd_col, rd_hi;
    logic                    gfx_tm;
    logic [`GFX_VRAM_AW-1:0] gfx_code_addr;
    logic [`GFX_YRAM_AW-1:0] gfx_col_addr;
    gfx_video_pkg::slot_e    slot_q;

    // addr 12 picks the byte lane for cpu writes
    always_ff @(posedge clk) begin
        if (vram_cs && !bus.rnw && !bus.addr[12])
            code_mem[bus.addr[11:0]][7:0] <= bus.dout;
        if (vram_cs && !bus.rnw && bus.addr[12])
            code_mem[bus.addr[11:0]][15:8] <= bus.dout;
        if (yram_we)
            col_mem[bus.addr[9:0]] <= bus.dout;
        cpu_code_q <= code_mem[bus.addr[11:0]];
        cpu_col_q  <= col_mem[bus.addr[9:0]];
    end

    // read data lands one cycle after the select
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_code <= 1'b0;
            rd_col  <= 1'b0;
            rd_hi   <= 1'b0;
        end else begin
            rd_code <= vram_cs && bus.rnw;
            rd_col  <= yram_cs && bus.rnw;
            rd_hi   <= bus.addr[12];
        end
    end

    // config reads fall through to zero
    assign cpu_din = rd_col  ? cpu_col_q :
                     rd_code ? (rd_hi ? cpu_code_q[15:8] : cpu_code_q[7:0]) :
                     8'h00;

    // free-running phase counter
    // flags decode the phase before, so they are high in phases 0 and 2
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_q   <= gfx_video_pkg::tm_a;
            tm_slot  <= 1'b0;
            obj_slot <= 1'b0;
        end else begin
            slot_q   <= gfx_video_pkg::slot_e'(slot_q + 2'd1);
            tm_slot  <= (slot_q == gfx_video_pkg::obj_b);
            obj_slot <= (slot_q == gfx_video_pkg::tm_b);
        end
    end

    // tilemap owns phases 0 and 1 and objects own 2 and 3
    assign gfx_tm        = (slot_q == gfx_video_pkg::tm_a) || (slot_q == gfx_video_pkg::tm_b);
    assign gfx_code_addr = gfx_tm ? tm_code_addr : obj_code_addr;
    assign gfx_col_addr  = gfx_tm ? tm_col_addr : obj_col_addr;

    // read-only graphics port
    always_ff @(posedge clk) begin
        code_data <= code_mem[gfx_code_addr];
        col_data  <= col_mem[gfx_col_addr];
    end

    a_slot_excl: assert property (
        @(posedge clk) disable iff (rst) !(tm_slot && obj_slot)
    );

endmodule

// File: test/gfx_tb.sv
`timescale 1ns/1ps

module gfx_tb;

    logic                    clk, rst, pxl_cen, hs, vram_cs, vctrl_cs, scr_ok, obj_ok, flip;
    logic [8:0]              vdump, vrender, hdump;
    logic [31:0]             scr_data, obj_data;
    logic [7:0]              cpu_din;
    gfx_cpu_pkg::cpu_bus_t   cpu_bus;
    gfx_video_pkg::rom_req_t scr_req, obj_req;
    gfx_video_pkg::pxl_t     scr_pxl, obj_pxl;

    // expected pixel for the pixel being driven, and for the one before it
    gfx_video_pkg::pxl_t     scr_exp, obj_exp, scr_chk, obj_chk;
    logic [15:0]             code_sh [4096];
    logic [7:0]              col_sh  [1024];
    logic                    sh_flip, sh_ven, chk_en, timed_out;
    logic [31:0]             rnd_stim, rnd_rom;
    int                      scr_wait, obj_wait, scr_fetch, obj_fetch;
    int                      errors, err_mark, tests, failed;

    gfx_top dut_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ROM contents, a hash of the word address
    function automatic logic [31:0] rom_hash(input logic [17:0] addr);
        logic [31:0] h;
        h = xorshift(xorshift({addr, 14'h0c63}));
        // sprite rows keep pixels 2 and 3 see-through
        if (addr[17])
            h = h & 32'hffff_00ff;
        return h;
    endfunction

    function automatic gfx_video_pkg::pxl_t scr_pixel(input logic [8:0] d, input logic [8:0] x);
        logic [7:0]  r, srow;
        logic [4:0]  c;
        logic [15:0] w;
        logic [31:0] row_bits;
        if (!sh_ven || x >= 9'd256)
            return '0;
        r        = d[7:0] ^ {8{sh_flip}};
        c        = x[7:3];
        srow     = r + col_sh[10'd512 + c];
        w        = code_sh[{2'b00, srow[7:3], c}];
        row_bits = rom_hash({4'd0, w[10:0], srow[2:0]});
        return '{pal: w[15:11], color: row_bits[4*x[2:0] +: 4]};
    endfunction

    function automatic gfx_video_pkg::pxl_t obj_pixel(input logic [8:0] d, input logic [8:0] x);
        gfx_video_pkg::pxl_t p;
        logic [7:0]          r, dy, i;
        logic [15:0]         w;
        logic [31:0]         row_bits;
        p = '0;
        if (!sh_ven || x >= 9'd256)
            return '0;
        r = d[7:0] ^ {8{sh_flip}};
        // walk downward so the lowest index is written last
        for (int n = 31; n >= 0; n--) begin
            dy       = r - col_sh[n];
            w        = code_sh[2048 + 2*n];
            i        = x[7:0] - code_sh[2049 + 2*n][7:0];
            row_bits = rom_hash({4'b1000, w[10:0], dy[2:0]});
            if (dy < 8'd8 && i < 8'd8 && row_bits[4*i[2:0] +: 4] != 4'd0)
                p = '{pal: w[15:11], color: row_bits[4*i[2:0] +: 4]};
        end
        return p;
    endfunction

    // pxl_cen on every other clock, 320 pixels per line, 256 lines
    always @(posedge clk) begin : video_timing
        #1;
        if (pxl_cen) begin
            pxl_cen = 1'b0;
        end else begin
            if (hdump == 9'd319) begin
                hdump = 9'd0;
                vdump = {1'b0, vdump[7:0] + 8'd1};
            end else begin
                hdump = hdump + 9'd1;
            end
            hs      = hdump < 9'd8;
            vrender = vdump + 9'd1;
            // previous pixel is due on the outputs two clocks from here
            scr_chk = scr_exp;
            obj_chk = obj_exp;
            scr_exp = scr_pixel(vdump, hdump);
            obj_exp = obj_pixel(vdump, hdump);
            pxl_cen = 1'b1;
        end
    end

    // both ROMs answer a held cs after a random delay
    always @(posedge clk) begin : rom_model
        #1;
        scr_ok = 1'b0;
        obj_ok = 1'b0;
        if (scr_wait != 0) begin
            scr_wait--;
            if (scr_wait == 0) begin
                scr_ok   = 1'b1;
                scr_data = rom_hash(scr_req.addr);
                scr_fetch++;
            end
        end else if (scr_req.cs) begin
            rnd_rom  = xorshift(rnd_rom);
            scr_wait = 1 + rnd_rom[1:0];
        end
        if (obj_wait != 0) begin
            obj_wait--;
            if (obj_wait == 0) begin
                obj_ok   = 1'b1;
                obj_data = rom_hash(obj_req.addr);
                obj_fetch++;
            end
        end else if (obj_req.cs) begin
            rnd_rom  = xorshift(rnd_rom);
            obj_wait = 1 + rnd_rom[1:0];
        end
    end

    a_scr_pxl: assert property (@(posedge clk) disable iff (rst || !chk_en)
        pxl_cen |-> ##2 (scr_pxl == scr_chk))
        else begin
            $display("Fail %0t: scr_pxl %h, expected %h", $time, $sampled(scr_pxl), scr_chk);
            errors++;
        end

    a_obj_pxl: assert property (@(posedge clk) disable iff (rst || !chk_en)
        pxl_cen |-> ##2 (obj_pxl == obj_chk))
        else begin
            $display("Fail %0t: obj_pxl %h, expected %h", $time, $sampled(obj_pxl), obj_chk);
            errors++;
        end

    a_scr_hold: assert property (@(posedge clk) disable iff (rst)
        scr_req.cs && !scr_ok |=> scr_req.cs && $stable(scr_req.addr))
        else begin
            $display("Fail %0t: scr_req dropped or moved before ok", $time);
            errors++;
        end

    a_obj_hold: assert property (@(posedge clk) disable iff (rst)
        obj_req.cs && !obj_ok |=> obj_req.cs && $stable(obj_req.addr))
        else begin
            $display("Fail %0t: obj_req dropped or moved before ok", $time);
            errors++;
        end

    // tiles in the lower ROM half, sprites in the upper
    a_rom_map: assert property (@(posedge clk) disable iff (rst)
        (scr_req.cs |-> scr_req.addr[17:14] == 4'd0) and
        (obj_req.cs |-> obj_req.addr[17:14] == 4'b1000))
        else begin
            $display("Fail %0t: ROM address outside its half", $time);
            errors++;
        end

    task automatic expect_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
        else begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // one bus access, select high for a single clock
    task automatic write_byte(input logic ctrl, input logic [12:0] addr, input logic [7:0] data);
        cpu_bus  = '{rnw: 1'b0, addr: addr, dout: data};
        vram_cs  = !ctrl;
        vctrl_cs = ctrl;
        @(posedge clk);
        #1;
        vram_cs  = 1'b0;
        vctrl_cs = 1'b0;
    endtask

    task automatic read_byte(input logic ctrl, input logic [12:0] addr, output logic [7:0] data);
        cpu_bus  = '{rnw: 1'b1, addr: addr, dout: 8'h00};
        vram_cs  = !ctrl;
        vctrl_cs = ctrl;
        @(posedge clk);
        #1;
        vram_cs  = 1'b0;
        vctrl_cs = 1'b0;
        data     = cpu_din;
    endtask

    task automatic put_code(input logic [11:0] addr, input logic [15:0] w);
        write_byte(1'b0, {1'b0, addr}, w[7:0]);
        write_byte(1'b0, {1'b1, addr}, w[15:8]);
        code_sh[addr] = w;
    endtask

    task automatic put_col(input logic [9:0] addr, input logic [7:0] b);
        write_byte(1'b1, {3'b000, addr}, b);
        col_sh[addr] = b;
    endtask

    task automatic set_cfg(input logic [1:0] idx, input logic [7:0] b);
        write_byte(1'b1, {5'b00011, 6'd0, idx}, b);
        if (idx == 2'd0) begin
            sh_flip = b[6];
            sh_ven  = b[4];
        end
    endtask

    task automatic wait_lines(input int n);
        int seen;
        int cnt;
        seen = 0;
        cnt  = 0;
        while (!timed_out && seen < n) begin
            @(posedge clk);
            cnt++;
            if (pxl_cen && hdump == 9'd0)
                seen++;
            if (cnt > 700 * (n + 1)) begin
                $display("timeout: no new video line within %0d clocks", cnt);
                timed_out = 1'b1;
                errors++;
            end
        end
        #1;
    endtask

    // let a full line render with the new data, then compare pixels
    task automatic check_window(input int settle, input int lines);
        wait_lines(settle);
        chk_en = 1'b1;
        wait_lines(lines);
        chk_en = 1'b0;
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors != err_mark) begin
            failed++;
            $display("test %-16s failed, %0d errors", name, errors - err_mark);
        end else begin
            $display("test %-16s ok", name);
        end
        err_mark = errors;
    endtask

    initial begin : main
        logic [7:0] got;
        logic [7:0] base;
        clk      = 1'b0;
        rst      = 1'b1;
        pxl_cen  = 1'b0;
        hs       = 1'b1;
        hdump    = 9'd0;
        vdump    = 9'd0;
        vrender  = 9'd1;
        cpu_bus  = '0;
        vram_cs  = 1'b0;
        vctrl_cs = 1'b0;
        scr_data = 32'd0;
        scr_ok   = 1'b0;
        obj_data = 32'd0;
        obj_ok   = 1'b0;
        scr_exp  = '0;
        obj_exp  = '0;
        scr_chk  = '0;
        obj_chk  = '0;
        sh_flip  = 1'b0;
        sh_ven   = 1'b0;
        chk_en   = 1'b0;
        rnd_stim = 32'hc063;
        rnd_rom  = 32'hc063;
        {scr_wait, obj_wait, scr_fetch, obj_fetch} = '0;
        {errors, err_mark, tests, failed} = '0;
        timed_out = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        expect_val(scr_req.cs, 1'b0, "scr_req.cs after reset");
        expect_val(obj_req.cs, 1'b0, "obj_req.cs after reset");
        expect_val(scr_pxl, 9'd0, "scr_pxl after reset");
        expect_val(obj_pxl, 9'd0, "obj_pxl after reset");
        expect_val(flip, 1'b0, "flip after reset");
        put_code(12'h123, 16'ha55a);
        read_byte(1'b0, 13'h0123, got);
        expect_val(got, 8'h5a, "code RAM low byte");
        read_byte(1'b0, 13'h1123, got);
        expect_val(got, 8'ha5, "code RAM high byte");
        put_col(10'h155, 8'h3c);
        read_byte(1'b1, 13'h0155, got);
        expect_val(got, 8'h3c, "column RAM byte");
        report_test("reset_access");

        set_cfg(2'd0, 8'h40);
        expect_val(flip, 1'b1, "flip after config write");
        read_byte(1'b1, 13'h0300, got);
        expect_val(got, 8'h00, "config region read");
        set_cfg(2'd0, 8'h00);
        expect_val(flip, 1'b0, "flip after clearing");
        report_test("config");

        // tile page 0, scroll bytes, random sprites
        for (int a = 0; a < 1024; a++) begin
            rnd_stim = xorshift(rnd_stim);
            put_code(12'(a), rnd_stim[15:0]);
        end
        for (int c = 0; c < 32; c++) begin
            rnd_stim = xorshift(rnd_stim);
            put_col(10'd512 + 10'(c), rnd_stim[7:0]);
            put_col(10'(c), rnd_stim[15:8]);
            put_code(12'(2048 + 2*c), rnd_stim[31:16]);
            put_code(12'(2049 + 2*c), rnd_stim[23:8]);
        end
        set_cfg(2'd0, 8'h10);
        check_window(2, 3);
        report_test("tilemap");
        set_cfg(2'd0, 8'h50);
        check_window(2, 3);
        report_test("tilemap_flip");

        // sprites a few lines below the current one, rest far off
        set_cfg(2'd0, 8'h10);
        base = vdump[7:0] + 8'd3;
        for (int n = 0; n < 32; n++) begin
            rnd_stim = xorshift(rnd_stim);
            put_col(10'(n), base + 8'd128);
            put_code(12'(2048 + 2*n), rnd_stim[15:0]);
            put_code(12'(2049 + 2*n), {8'h00, rnd_stim[23:16]});
        end
        // 0 and 1 overlap, 1 shows through the clear pixels of 0
        put_col(10'd0, base);
        put_code(12'd2049, 16'd40);
        put_col(10'd1, base + 8'd3);
        put_code(12'd2051, 16'd42);
        // 2 wraps at the right edge
        put_col(10'd2, base + 8'd1);
        put_code(12'd2053, 16'd252);
        check_window(2, 10);
        report_test("sprites");

        expect_val(scr_fetch > 0 && obj_fetch > 0, 1'b1, "ROM fetches completed");
        report_test("rom_fetch");

        set_cfg(2'd0, 8'h00);
        check_window(2, 2);
        expect_val(scr_pxl, 9'd0, "scr_pxl with video off");
        expect_val(obj_pxl, 9'd0, "obj_pxl with video off");
        report_test("video_off");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
